//--- Bender.yml
package:
  name: mips_soc

sources:
  - hw/bus_pkg.sv
  - hw/mips_pkg.sv
  - hw/wb_arbiter.sv
  - hw/wb_sram.sv
  - hw/fetch_unit.sv
  - hw/datapath.sv
  - hw/load_store_unit.sv
  - hw/mips_soc.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/tb_mips_soc.sv

//--- bench/tb_tasks.svh
`ifndef tb_tasks_svh
`define tb_tasks_svh

// xorshift32
function automatic word_t next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

function automatic logic [15:0] random_half();
    word_t r;
    r = next_random();
    return r[15:0];
endfunction

// instruction encoders, operand order as in assembly
function automatic word_t enc_r(funct_e fn, logic [4:0] rd, logic [4:0] rs, logic [4:0] rt);
    return {op_special, rs, rt, rd, 5'd0, fn};
endfunction

function automatic word_t enc_i(opcode_e op, logic [4:0] rt, logic [4:0] rs, logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic word_t enc_beq(logic [4:0] rs, logic [4:0] rt, logic [15:0] offset);
    return {op_beq, rs, rt, offset};
endfunction

function automatic int word_index(word_t byte_addr);
    return int'((byte_addr >> 2) % mem_words);
endfunction

task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
        $display("ERROR @%0t: %s is %h, expected %h", $time, what, got, exp);
        fail_run();
    end
endtask

task automatic check_rf(input string what, input rf_w_t got, input rf_w_t exp);
    if (got !== exp) begin
        $display("ERROR @%0t: %s is valid %b addr %0d data %h, expected valid %b addr %0d data %h",
            $time, what, got.valid, got.addr, got.data, exp.valid, exp.addr, exp.data);
        fail_run();
    end
endtask

// one wishbone classic transfer on the host port
task automatic host_cycle(input logic we, input word_t adr, input word_t dat,
                          output word_t rdata);
    @(posedge clk);
    #1;
    host_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    do begin
        @(posedge clk);
        #1;
    end while (!host_rsp.ack);
    rdata = host_rsp.dat;
    // request held through the ack cycle so that a repeated ack shows here
    @(posedge clk);
    #1;
    if (host_rsp.ack !== 1'b0) begin
        $display("host port got a second ack for one access at address %h", adr);
        fail_run();
    end
    host_req = '0;
endtask

task automatic host_write(input word_t adr, input word_t data);
    word_t unused;
    host_cycle(1'b1, adr, data, unused);
    model_mem[int'(adr % mem_words)] = data;
endtask

task automatic host_read(input word_t adr, output word_t data);
    host_cycle(1'b0, adr, '0, data);
endtask

task automatic wait_retire(output rf_w_t got_rf, output word_t got_pc);
    do begin
        @(posedge clk);
        #1;
    end while (!rfwrite.valid);
    got_rf = rfwrite;
    got_pc = wb_pc;
endtask

// program at reset_pc, followed by a branch to itself as a stop guard
task automatic load_program(input word_t prog [$], output word_t end_pc);
    foreach (prog[i]) begin
        host_write((reset_pc >> 2) + i, prog[i]);
    end
    end_pc = reset_pc + 32'(4 * prog.size());
    host_write(end_pc >> 2, enc_beq(5'd0, 5'd0, 16'hffff));
endtask

// instruction-set model, updates model_rf and model_mem
task automatic model_exec(input word_t pc, output rf_w_t exp, output word_t npc);
    word_t      ins;
    word_t      a;
    word_t      b;
    word_t      sext;
    word_t      res;
    logic [4:0] dst;
    ins  = model_mem[word_index(pc)];
    a    = model_rf[ins[25:21]];
    b    = model_rf[ins[20:16]];
    sext = {{16{ins[15]}}, ins[15:0]};
    res  = '0;
    dst  = 5'd0;
    npc  = pc + 32'd4;
    case (ins[31:26])
        op_special: begin
            dst = ins[15:11];
            case (ins[5:0])
                fn_addu: res = a + b;
                fn_subu: res = a - b;
                fn_and:  res = a & b;
                fn_or:   res = a | b;
                fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default: dst = 5'd0;
            endcase
        end
        op_addiu: begin
            dst = ins[20:16];
            res = a + sext;
        end
        op_lui: begin
            dst = ins[20:16];
            res = {ins[15:0], 16'h0000};
        end
        op_lw: begin
            dst = ins[20:16];
            res = model_mem[word_index(a + sext)];
        end
        op_sw: begin
            model_mem[word_index(a + sext)] = b;
        end
        op_beq: begin
            if (a == b) begin
                npc = pc + 32'd4 + (sext << 2);
            end
        end
        default: ;
    endcase
    // r0 reports no write
    if (dst == 5'd0) begin
        res = '0;
    end else begin
        model_rf[dst] = res;
    end
    exp = '{valid: 1'b1, addr: dst, data: res};
endtask

`endif

//--- bench/tb_mips_soc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_soc import bus_pkg::*; import mips_pkg::*; ();

    localparam int    mem_words = 1024;
    localparam word_t reset_pc  = '0;
    // alu 12, load/store 8, branches 6, two loop runs of 25, restart 3 + 25
    localparam int total_instrs    = 12 + 8 + 6 + 2 * 25 + 3 + 25;
    localparam int watchdog_cycles = total_instrs * 20 + 2000;

    logic    clk;
    logic    reset;
    logic    run;
    wb_req_t host_req;
    wb_rsp_t host_rsp;
    rf_w_t   rfwrite;
    word_t   wb_pc;

    word_t rng_state;
    // reference state of the processor
    word_t model_rf [32];
    word_t model_mem [mem_words];
    // host addresses written in the memory test
    word_t written [$];
    // retire history of the last program run
    word_t pc_log [$];
    rf_w_t rf_log [$];

    mips_soc #(.mem_words(mem_words), .reset_pc(reset_pc)) dut0 (
        .clk, .reset, .run, .host_req, .host_rsp, .rfwrite, .wb_pc
    );

    always #4 clk = ~clk;

    task automatic fail_run();
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    `include "tb_tasks.svh"

    // starts the core and checks every retirement until end_pc or max_retire
    task automatic run_program(input word_t end_pc, input int max_retire);
        rf_w_t got;
        rf_w_t exp;
        word_t got_pc;
        word_t pc;
        word_t npc;
        int    count;
        pc    = reset_pc;
        count = 0;
        pc_log.delete();
        rf_log.delete();
        @(posedge clk);
        #1;
        run = 1'b1;
        do begin
            wait_retire(got, got_pc);
            model_exec(pc, exp, npc);
            check_word("wb_pc", got_pc, pc);
            check_rf("rfwrite", got, exp);
            pc_log.push_back(got_pc);
            rf_log.push_back(got);
            pc = npc;
            count++;
        end while (pc != end_pc && count != max_retire);
        // dropped inside the retire cycle, so no further fetch starts
        run = 1'b0;
    endtask

    task automatic test_host_memory();
        word_t adr;
        word_t data;
        word_t got;
        for (int i = 0; i < 16; i++) begin
            adr  = 32'd512 + (next_random() % 512);
            data = next_random();
            host_write(adr, data);
            written.push_back(adr);
        end
        foreach (written[i]) begin
            host_read(written[i], got);
            check_word("host_rsp.dat", got, model_mem[written[i]]);
        end
    endtask

    task automatic test_alu();
        word_t prog [$];
        word_t end_pc;
        prog.push_back(enc_i(op_lui, 5'd1, 5'd0, random_half()));
        prog.push_back(enc_i(op_addiu, 5'd1, 5'd1, random_half()));
        prog.push_back(enc_i(op_lui, 5'd2, 5'd0, random_half()));
        prog.push_back(enc_i(op_addiu, 5'd2, 5'd2, random_half()));
        prog.push_back(enc_r(fn_addu, 5'd3, 5'd1, 5'd2));
        prog.push_back(enc_r(fn_subu, 5'd4, 5'd1, 5'd2));
        prog.push_back(enc_r(fn_and, 5'd5, 5'd1, 5'd2));
        prog.push_back(enc_r(fn_or, 5'd6, 5'd1, 5'd2));
        prog.push_back(enc_r(fn_slt, 5'd7, 5'd1, 5'd2));
        prog.push_back(enc_r(fn_slt, 5'd8, 5'd2, 5'd1));
        prog.push_back(enc_i(op_addiu, 5'd9, 5'd0, random_half()));
        prog.push_back(enc_r(fn_slt, 5'd10, 5'd9, 5'd0));
        load_program(prog, end_pc);
        run_program(end_pc, 0);
        // straight-line code, pc steps by one word
        foreach (pc_log[i]) begin
            check_word("wb_pc step", pc_log[i], reset_pc + 32'(4 * i));
        end
    endtask

    task automatic test_load_store();
        word_t prog [$];
        word_t end_pc;
        word_t got;
        prog.push_back(enc_i(op_lui, 5'd1, 5'd0, random_half()));
        prog.push_back(enc_i(op_addiu, 5'd1, 5'd1, random_half()));
        prog.push_back(enc_r(fn_addu, 5'd2, 5'd1, 5'd1));
        prog.push_back(enc_i(op_addiu, 5'd3, 5'd0, 16'h0600));
        prog.push_back(enc_i(op_sw, 5'd2, 5'd3, 16'h0008));
        prog.push_back(enc_i(op_lw, 5'd4, 5'd3, 16'h0008));
        prog.push_back(enc_i(op_sw, 5'd4, 5'd3, 16'hfffc));
        prog.push_back(enc_i(op_lw, 5'd5, 5'd3, 16'hfffc));
        load_program(prog, end_pc);
        run_program(end_pc, 0);
        // byte 0x608 is word 386, byte 0x5fc is word 383
        host_read(32'd386, got);
        check_word("stored word 386", got, model_rf[2]);
        host_read(32'd383, got);
        check_word("stored word 383", got, model_rf[2]);
    endtask

    task automatic test_branches();
        word_t prog [$];
        word_t exp_pcs [$];
        word_t end_pc;
        exp_pcs = '{32'd0, 32'd4, 32'd8, 32'd12, 32'd24, 32'd28};
        prog.push_back(enc_i(op_addiu, 5'd1, 5'd0, 16'd5));
        prog.push_back(enc_i(op_addiu, 5'd2, 5'd0, 16'd5));
        prog.push_back(enc_i(op_addiu, 5'd3, 5'd0, 16'd7));
        // taken, skips the next two
        prog.push_back(enc_beq(5'd1, 5'd2, 16'd2));
        prog.push_back(enc_i(op_addiu, 5'd4, 5'd0, 16'd1));
        prog.push_back(enc_i(op_addiu, 5'd4, 5'd0, 16'd2));
        // not taken
        prog.push_back(enc_beq(5'd1, 5'd3, 16'd1));
        prog.push_back(enc_i(op_addiu, 5'd5, 5'd0, 16'd3));
        load_program(prog, end_pc);
        run_program(end_pc, 0);
        check_word("retire count", word_t'(pc_log.size()), word_t'(exp_pcs.size()));
        foreach (exp_pcs[i]) begin
            check_word("wb_pc sequence", pc_log[i], exp_pcs[i]);
        end
        check_word("taken beq rfwrite.addr", word_t'(rf_log[3].addr), '0);
        check_word("untaken beq rfwrite.addr", word_t'(rf_log[4].addr), '0);
    endtask

    task automatic test_arbitration(output word_t end_pc);
        word_t prog [$];
        word_t ref_pcs [$];
        rf_w_t ref_rfs [$];
        word_t adr;
        word_t got;
        for (int i = 0; i < 3; i++) begin
            host_write(32'd256 + i, next_random());
        end
        // four passes over three loads, counted in r10
        prog.push_back(enc_i(op_addiu, 5'd11, 5'd0, 16'd4));
        prog.push_back(enc_i(op_addiu, 5'd10, 5'd0, 16'd0));
        prog.push_back(enc_i(op_lw, 5'd12, 5'd0, 16'h0400));
        prog.push_back(enc_i(op_lw, 5'd13, 5'd0, 16'h0404));
        prog.push_back(enc_i(op_lw, 5'd14, 5'd0, 16'h0408));
        prog.push_back(enc_i(op_addiu, 5'd10, 5'd10, 16'd1));
        prog.push_back(enc_beq(5'd10, 5'd11, 16'd1));
        prog.push_back(enc_beq(5'd0, 5'd0, 16'hfffa));
        load_program(prog, end_pc);
        run_program(end_pc, 0);
        ref_pcs = pc_log;
        ref_rfs = rf_log;
        fork
            run_program(end_pc, 0);
            begin
                for (int i = 0; i < 12; i++) begin
                    adr = written[next_random() % written.size()];
                    host_read(adr, got);
                    check_word("host_rsp.dat under load", got, model_mem[adr]);
                end
            end
        join
        check_word("retire count", word_t'(pc_log.size()), word_t'(ref_pcs.size()));
        foreach (ref_pcs[i]) begin
            check_word("wb_pc against quiet run", pc_log[i], ref_pcs[i]);
            check_rf("rfwrite against quiet run", rf_log[i], ref_rfs[i]);
        end
    endtask

    task automatic test_restart(input word_t end_pc);
        // stop after three instructions, then start over
        run_program(end_pc, 3);
        repeat (5) @(posedge clk);
        run_program(end_pc, 0);
        check_word("first wb_pc after restart", pc_log[0], reset_pc);
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", watchdog_cycles);
        fail_run();
    end

    initial begin
        word_t loop_end;
        clk       = 1'b0;
        reset     = 1'b1;
        run       = 1'b0;
        host_req  = '0;
        rng_state = 32'd39427;
        for (int i = 0; i < 32; i++) begin
            model_rf[i] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        test_host_memory();
        test_alu();
        test_load_store();
        test_branches();
        test_arbitration(loop_end);
        test_restart(loop_end);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+bench
hw/bus_pkg.sv
hw/mips_pkg.sv
hw/wb_arbiter.sv
hw/wb_sram.sv
hw/fetch_unit.sv
hw/datapath.sv
hw/load_store_unit.sv
hw/mips_soc.sv
bench/tb_mips_soc.sv

//--- hw/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // master to slave half of a wishbone classic link
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        // word address, not byte address
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    // slave to master half
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // arbiter requesters, listed in priority order
    typedef enum logic [1:0] {
        mst_host  = 2'd0,
        mst_lsu   = 2'd1,
        mst_fetch = 2'd2
    } master_e;

endpackage

`default_nettype wire

//--- hw/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath import mips_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  run,
    output logic  fetch_go,
    output logic  branch_taken,
    output word_t branch_offset,
    input  word_t pc,
    input  word_t instr,
    input  logic  instr_valid,
    output logic  mem_go,
    output logic  mem_we,
    output word_t mem_addr,
    output word_t store_data,
    input  word_t load_data,
    input  logic  mem_done,
    output rf_w_t rfwrite,
    output word_t wb_pc
);
    typedef enum logic [2:0] {s_idle, s_fetch, s_execute, s_memory, s_retire} state_e;

    state_e     state;
    word_t      ir;
    word_t      cur_pc;
    word_t      rf [32];
    decoded_t   dec;
    opcode_e    opcode;
    funct_e     funct;
    word_t      rs_val;
    word_t      rt_val;
    word_t      imm_val;
    word_t      alu_b;
    word_t      alu_y;
    word_t      result;
    logic [4:0] dest;
    logic       is_mem;
    logic       retiring;

    assign opcode = opcode_e'(ir[31:26]);
    assign funct  = funct_e'(ir[5:0]);

    // decoder, anything unknown falls out as a no-op
    always_comb begin
        dec        = '0;
        dec.alu_op = alu_add;
        case (opcode)
            op_special: begin
                dec.reg_write = 1'b1;
                dec.dest      = ir[15:11];
                case (funct)
                    fn_addu: dec.alu_op = alu_add;
                    fn_subu: dec.alu_op = alu_sub;
                    fn_and:  dec.alu_op = alu_and;
                    fn_or:   dec.alu_op = alu_or;
                    fn_slt:  dec.alu_op = alu_slt;
                    default: dec.reg_write = 1'b0;
                endcase
            end
            op_addiu: begin
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                dec.dest      = ir[20:16];
            end
            op_lui: begin
                dec.alu_op    = alu_pass_b;
                dec.use_imm   = 1'b1;
                dec.upper_imm = 1'b1;
                dec.reg_write = 1'b1;
                dec.dest      = ir[20:16];
            end
            op_lw: begin
                dec.use_imm   = 1'b1;
                dec.mem_read  = 1'b1;
                dec.reg_write = 1'b1;
                dec.dest      = ir[20:16];
            end
            op_sw: begin
                dec.use_imm   = 1'b1;
                dec.mem_write = 1'b1;
            end
            op_beq: begin
                dec.alu_op = alu_sub;
                dec.branch = 1'b1;
            end
            default: ;
        endcase
    end

    assign rs_val  = rf[ir[25:21]];
    assign rt_val  = rf[ir[20:16]];
    assign imm_val = dec.upper_imm ? {ir[15:0], 16'h0000} : {{16{ir[15]}}, ir[15:0]};
    assign alu_b   = dec.use_imm ? imm_val : rt_val;

    always_comb begin
        case (dec.alu_op)
            alu_add:    alu_y = rs_val + alu_b;
            alu_sub:    alu_y = rs_val - alu_b;
            alu_and:    alu_y = rs_val & alu_b;
            alu_or:     alu_y = rs_val | alu_b;
            alu_slt:    alu_y = {31'd0, $signed(rs_val) < $signed(alu_b)};
            default:    alu_y = alu_b;
        endcase
    end

    assign is_mem = dec.mem_read || dec.mem_write;
    // non-memory ops retire in execute, memory ops one cycle after mem_done
    assign retiring = (state == s_execute && !is_mem) || state == s_retire;

    assign fetch_go      = run && (state == s_idle || retiring);
    assign branch_taken  = retiring && dec.branch && alu_y == '0;
    assign branch_offset = {{14{ir[15]}}, ir[15:0], 2'b00};

    assign mem_go     = state == s_execute && is_mem;
    assign mem_we     = dec.mem_write;
    assign mem_addr   = alu_y;
    assign store_data = rt_val;

    assign dest   = dec.reg_write ? dec.dest : 5'd0;
    assign result = dec.mem_read ? load_data : alu_y;

    assign rfwrite.valid = retiring;
    assign rfwrite.addr  = retiring ? dest : 5'd0;
    assign rfwrite.data  = (retiring && dest != 5'd0) ? result : '0;
    assign wb_pc         = cur_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_idle;
        end else begin
            case (state)
                s_idle: begin
                    if (run) begin
                        state <= s_fetch;
                    end
                end
                s_fetch: begin
                    if (instr_valid) begin
                        state <= s_execute;
                    end
                end
                s_execute: begin
                    if (is_mem) begin
                        state <= s_memory;
                    end else begin
                        state <= run ? s_fetch : s_idle;
                    end
                end
                s_memory: begin
                    if (mem_done) begin
                        state <= s_retire;
                    end
                end
                default: state <= run ? s_fetch : s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_fetch && instr_valid) begin
            ir     <= instr;
            cur_pc <= pc;
        end
    end

    // register file, r0 is never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (rfwrite.valid && rfwrite.addr != 5'd0) begin
            rf[rfwrite.addr] <= rfwrite.data;
        end
    end

    a_r0_clean: assert property (@(posedge clk) disable iff (reset)
        rfwrite.valid |-> (rfwrite.addr != 5'd0 || rfwrite.data == '0) ##1 rf[0] == '0);

endmodule

`default_nettype wire

//--- hw/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import bus_pkg::*; import mips_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    fetch_go,
    input  logic    branch_taken,
    input  word_t   branch_offset,
    input  logic    run,
    output word_t   pc,
    output word_t   instr,
    output logic    instr_valid,
    output wb_req_t bus_req,
    input  wb_rsp_t bus_rsp
);
    logic  busy;
    logic  started;
    word_t next_pc;

    // first fetch after a start uses reset_pc as is
    always_comb begin
        if (!started) begin
            next_pc = reset_pc;
        end else if (branch_taken) begin
            next_pc = pc + 32'd4 + branch_offset;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc          <= reset_pc;
            started     <= 1'b0;
            busy        <= 1'b0;
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= 1'b0;
            if (fetch_go) begin
                pc      <= next_pc;
                started <= 1'b1;
                busy    <= 1'b1;
            end else if (busy && bus_rsp.ack) begin
                busy        <= 1'b0;
                instr_valid <= 1'b1;
            end else if (!run && !busy) begin
                // stopped, next start begins at reset_pc again
                pc      <= reset_pc;
                started <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy && bus_rsp.ack) begin
            instr <= bus_rsp.dat;
        end
    end

    assign bus_req = '{cyc: busy, stb: busy, we: 1'b0, adr: {2'b00, pc[31:2]}, dat: '0};

endmodule

`default_nettype wire

//--- hw/load_store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_unit import bus_pkg::*; import mips_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    mem_go,
    input  logic    mem_we,
    input  word_t   mem_addr,
    input  word_t   store_data,
    output word_t   load_data,
    output logic    mem_done,
    output wb_req_t bus_req,
    input  wb_rsp_t bus_rsp
);
    logic  busy;
    logic  we;
    word_t adr;
    word_t dat;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= busy && bus_rsp.ack;
            if (mem_go) begin
                busy <= 1'b1;
            end else if (bus_rsp.ack) begin
                busy <= 1'b0;
            end
        end
    end

    // request fields stay put until ack
    always_ff @(posedge clk) begin
        if (mem_go) begin
            we  <= mem_we;
            adr <= {2'b00, mem_addr[31:2]};
            dat <= store_data;
        end
        if (busy && bus_rsp.ack && !we) begin
            load_data <= bus_rsp.dat;
        end
    end

    assign bus_req = '{cyc: busy, stb: busy, we: we, adr: adr, dat: dat};

    a_no_overlap: assert property (@(posedge clk) disable iff (reset)
        mem_go |-> !busy);

endmodule

`default_nettype wire

//--- hw/mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;

    // primary opcodes, instr[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_beq     = 6'h04,
        op_addiu   = 6'h09,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // special functs, instr[5:0]
    typedef enum logic [5:0] {
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_slt  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_pass_b
    } alu_op_e;

    typedef struct packed {
        alu_op_e    alu_op;
        // b operand from the immediate field
        logic       use_imm;
        // immediate goes to the upper half (lui)
        logic       upper_imm;
        logic       reg_write;
        logic [4:0] dest;
        logic       mem_read;
        logic       mem_write;
        logic       branch;
    } decoded_t;

    // retirement report, addr 0 means no register written
    typedef struct packed {
        logic       valid;
        logic [4:0] addr;
        word_t      data;
    } rf_w_t;

endpackage

`default_nettype wire

//--- hw/mips_soc.sv
`timescale 1ns/1ps
`default_nettype none

module mips_soc import bus_pkg::*; import mips_pkg::*; #(
    parameter int    mem_words = 1024,
    parameter word_t reset_pc  = '0
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    run,
    input  wb_req_t host_req,
    output wb_rsp_t host_rsp,
    output rf_w_t   rfwrite,
    output word_t   wb_pc
);
    logic    fetch_go;
    logic    branch_taken;
    word_t   branch_offset;
    word_t   pc;
    word_t   instr;
    logic    instr_valid;
    logic    mem_go;
    logic    mem_we;
    word_t   mem_addr;
    word_t   store_data;
    word_t   load_data;
    logic    mem_done;
    wb_req_t fetch_req;
    wb_rsp_t fetch_rsp;
    wb_req_t lsu_req;
    wb_rsp_t lsu_rsp;
    wb_req_t mem_req;
    wb_rsp_t mem_rsp;

    fetch_unit #(.reset_pc(reset_pc)) fetch0 (
        .clk, .reset, .fetch_go, .branch_taken, .branch_offset, .run,
        .pc, .instr, .instr_valid, .bus_req(fetch_req), .bus_rsp(fetch_rsp)
    );

    datapath datapath0 (
        .clk, .reset, .run, .fetch_go, .branch_taken, .branch_offset,
        .pc, .instr, .instr_valid, .mem_go, .mem_we, .mem_addr, .store_data,
        .load_data, .mem_done, .rfwrite, .wb_pc
    );

    load_store_unit lsu0 (
        .clk, .reset, .mem_go, .mem_we, .mem_addr, .store_data, .load_data,
        .mem_done, .bus_req(lsu_req), .bus_rsp(lsu_rsp)
    );

    wb_arbiter #(.mem_words(mem_words)) arbiter0 (
        .clk, .reset, .host_req, .lsu_req, .fetch_req, .host_rsp, .lsu_rsp,
        .fetch_rsp, .mem_req, .mem_rsp
    );

    wb_sram #(.mem_words(mem_words)) sram0 (
        .clk, .reset, .req(mem_req), .rsp(mem_rsp)
    );

endmodule

`default_nettype wire

//--- hw/wb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter import bus_pkg::*; #(
    parameter int mem_words = 1024
) (
    input  logic    clk,
    input  logic    reset,
    input  wb_req_t host_req,
    input  wb_req_t lsu_req,
    input  wb_req_t fetch_req,
    output wb_rsp_t host_rsp,
    output wb_rsp_t lsu_rsp,
    output wb_rsp_t fetch_rsp,
    output wb_req_t mem_req,
    input  wb_rsp_t mem_rsp
);
    localparam int addr_bits = $clog2(mem_words);

    master_e grant;
    master_e next_grant;
    logic    owned;
    logic    any_cyc;
    wb_req_t sel_req;

    always_comb begin
        case (grant)
            mst_host: sel_req = host_req;
            mst_lsu:  sel_req = lsu_req;
            default:  sel_req = fetch_req;
        endcase
    end

    // fixed priority, host first
    always_comb begin
        next_grant = grant;
        if (host_req.cyc) begin
            next_grant = mst_host;
        end else if (lsu_req.cyc) begin
            next_grant = mst_lsu;
        end else if (fetch_req.cyc) begin
            next_grant = mst_fetch;
        end
    end

    assign any_cyc = host_req.cyc | lsu_req.cyc | fetch_req.cyc;

    // re-arbitrate only once the owner has let go of cyc
    always_ff @(posedge clk) begin
        if (reset) begin
            grant <= mst_host;
            owned <= 1'b0;
        end else if (!owned || !sel_req.cyc) begin
            grant <= next_grant;
            owned <= any_cyc;
        end
    end

    always_comb begin
        mem_req = '0;
        if (owned) begin
            mem_req     = sel_req;
            // fold the address into the memory range
            mem_req.adr = 32'(sel_req.adr[addr_bits-1:0]);
        end
    end

    // read data fans out, ack only to the owner
    always_comb begin
        host_rsp  = '{ack: 1'b0, dat: mem_rsp.dat};
        lsu_rsp   = '{ack: 1'b0, dat: mem_rsp.dat};
        fetch_rsp = '{ack: 1'b0, dat: mem_rsp.dat};
        if (owned) begin
            case (grant)
                mst_host: host_rsp.ack = mem_rsp.ack;
                mst_lsu:  lsu_rsp.ack = mem_rsp.ack;
                default:  fetch_rsp.ack = mem_rsp.ack;
            endcase
        end
    end

    a_ack_needs_cyc: assert property (@(posedge clk) disable iff (reset)
        (host_rsp.ack -> host_req.cyc) && (lsu_rsp.ack -> lsu_req.cyc) &&
        (fetch_rsp.ack -> fetch_req.cyc));

    a_grant_held: assert property (@(posedge clk) disable iff (reset)
        owned && sel_req.cyc |=> grant == $past(grant));

endmodule

`default_nettype wire

//--- hw/wb_sram.sv
`timescale 1ns/1ps
`default_nettype none

module wb_sram import bus_pkg::*; #(
    parameter int mem_words = 1024
) (
    input  logic    clk,
    input  logic    reset,
    input  wb_req_t req,
    output wb_rsp_t rsp
);
    localparam int addr_bits = $clog2(mem_words);

    logic [31:0]          mem [mem_words];
    logic                 ack;
    logic [31:0]          rdata;
    logic [addr_bits-1:0] index;
    logic                 access;

    assign index = req.adr[addr_bits-1:0];
    // skip the cycle that already carries ack, so one ack per stb
    assign access = req.cyc && req.stb && !ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (req.we) begin
                mem[index] <= req.dat;
            end
            rdata <= mem[index];
        end
    end

    assign rsp = '{ack: ack, dat: rdata};

    a_ack_after_stb: assert property (@(posedge clk) disable iff (reset)
        rsp.ack |-> $past(req.cyc && req.stb));

endmodule

`default_nettype wire
